// ==== mdec_stim.txt ====
# cmd, hex fields: R byte_num | S word cont bad_par | G cycles | C clear | F dec_fsm
# E error_code parity_err unk_instr_err | W addr we data | D writes_before_done
R 5
S D0 1 0
S 00 1 0
S 01 1 0
S 02 1 0
S 03 0 0
F 3
S 11 1 0
S 22 1 0
S 33 1 0
S 44 1 0
S 55 1 0
S 66 0 0
F 0
W 0 1 00000011
W 0 2 00002200
W 0 4 00330000
W 0 8 44000000
W 1 1 00000055
W 1 2 00006600
D 6
R 0
S D0 1 0
S 00 1 0
S 00 1 0
S 00 1 0
S 00 0 0
S A5 0 0
W 0 1 000000A5
D 7
S E0 1 0
S 5A 0 0
E 5A 0 0
C
E 00 0 0
S 98 1 0
F 7
S 00 0 0
F 0
E 00 0 1
S 01 0 1
E 00 1 1
G 4
E 00 1 1
C
E 00 0 0

// ==== filelist.f ====
hsci_mdec_pkg.sv
mdec_dec_if.sv
mdec_frame_fsm.sv
mdec_err_regs.sv
mdec_rdata_pack.sv
mdec_read_tally.sv
hsci_mdec_top.sv
tb_hsci_mdec.sv

// ==== Makefile ====
TOP = tb_hsci_mdec

all: run

run: build
	./obj_dir/V$(TOP)

build:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module hsci_mdec_top -f filelist.f

clean:
	rm -rf obj_dir

.PHONY: all run build lint clean

// ==== tb_hsci_mdec.sv ====
module tb_hsci_mdec
   import hsci_mdec_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 200;   // cycles per wait

   logic              hsci_pclk;
   logic              rstn;
   logic [SFRM_W-1:0] mdec_sfrm;
   logic              mdec_val;
   logic              clear_errors;
   logic              read_op;
   logic [BCNT_W-1:0] read_byte_num;
   logic [ADDR_W-1:0] dec_addr;
   logic [DATA_W-1:0] dec_data;
   logic              dec_en;
   logic [LANES-1:0]  dec_we;
   dec_state_t        dec_fsm;
   logic [WORD_W-1:0] error_code;
   logic              parity_err;
   logic              unk_instr_err;
   logic              read_done;

   // observed writes and read_done pulses
   logic [ADDR_W-1:0] wr_addr_q[$];
   logic [LANES-1:0]  wr_we_q[$];
   logic [DATA_W-1:0] wr_data_q[$];
   int                done_len_q[$];
   int                done_wr_q[$];
   int                wr_seen = 0;
   int                done_run = 0;
   int                rise_wr = 0;

   int                fd;
   int                nf;
   string             line;
   logic [7:0]        cmd;
   logic [31:0]       fa;
   logic [31:0]       fb;
   logic [31:0]       fc;

   hsci_mdec_top u_hsci_mdec_top
   (
      .hsci_pclk     (hsci_pclk),
      .rstn          (rstn),
      .mdec_sfrm     (mdec_sfrm),
      .mdec_val      (mdec_val),
      .dec_addr      (dec_addr),
      .dec_data      (dec_data),
      .dec_en        (dec_en),
      .dec_we        (dec_we),
      .dec_fsm       (dec_fsm),
      .error_code    (error_code),
      .clear_errors  (clear_errors),
      .parity_err    (parity_err),
      .unk_instr_err (unk_instr_err),
      .read_op       (read_op),
      .read_byte_num (read_byte_num),
      .read_done     (read_done)
   );

   initial
   begin
      hsci_pclk = 1'b0;
      forever #50 hsci_pclk = ~hsci_pclk;
   end

   // ******************************
   // write and read_done monitor on the falling edge
   // ******************************
   always @(negedge hsci_pclk)
   begin
      if (rstn && dec_en)
      begin
         wr_addr_q.push_back(dec_addr);
         wr_we_q.push_back(dec_we);
         wr_data_q.push_back(dec_data);
         wr_seen++;
      end
      if (read_done)
      begin
         if (done_run == 0)
            rise_wr = wr_seen;   // writes seen when done rose
         done_run++;
      end
      else if (done_run != 0)
      begin
         done_len_q.push_back(done_run);
         done_wr_q.push_back(rise_wr);
         done_run = 0;
      end
   end

   task automatic abort_run(input string why);
      begin
         $display("%s", why);
         $display("=== FAIL ===");
         $fatal(1, "simulation stopped");
      end
   endtask

   task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
      begin
         if (got !== exp)
         begin
            $display("Fail at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
         end
      end
   endtask

   // all drive tasks start and end 5 ns after a rising edge
   task automatic idle_cycles(input logic [31:0] n);
      begin
         repeat (n)
         begin
            @(posedge hsci_pclk);
            #5;
         end
      end
   endtask

   task automatic drive_sfrm(input logic [7:0] word, input logic cont, input logic bad_par);
      logic par;
      begin
         par = ~^{word, cont};   // odd count of ones overall
         if (bad_par)
            par = ~par;
         mdec_sfrm = {word, par, cont};
         mdec_val  = 1'b1;
         idle_cycles(1);
         mdec_val  = 1'b0;
         mdec_sfrm = '0;
      end
   endtask

   task automatic pulse_read(input logic [BCNT_W-1:0] num);
      begin
         read_byte_num = num;
         read_op       = 1'b1;
         idle_cycles(1);
         read_op       = 1'b0;
      end
   endtask

   task automatic pulse_clear();
      begin
         clear_errors = 1'b1;
         idle_cycles(1);
         clear_errors = 1'b0;
      end
   endtask

   task automatic expect_write(input logic [31:0] addr, input logic [31:0] we,
                               input logic [31:0] data);
      int waited;
      begin
         waited = 0;
         while (wr_addr_q.size() == 0)
         begin
            if (waited == WAIT_LIMIT)
               abort_run("timeout, an expected memory write never appeared");
            else
            begin
               idle_cycles(1);
               waited++;
            end
         end
         check_val(32'(wr_addr_q.pop_front()), addr, "dec_addr");
         check_val(32'(wr_we_q.pop_front()), we, "dec_we");
         check_val(wr_data_q.pop_front(), data, "dec_data");
      end
   endtask

   task automatic expect_done(input logic [31:0] nwr);
      int waited;
      begin
         waited = 0;
         while (done_len_q.size() == 0)
         begin
            if (waited == WAIT_LIMIT)
               abort_run("timeout, read_done pulse never completed");
            else
            begin
               idle_cycles(1);
               waited++;
            end
         end
         check_val(32'(done_len_q.pop_front()), 32'd2, "read_done high cycles");
         check_val(32'(done_wr_q.pop_front()), nwr, "writes before read_done");
      end
   endtask

   task automatic run_cmd(input logic [7:0] c, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] d);
      begin
         case (c)
            "R": pulse_read(a[BCNT_W-1:0]);
            "S": drive_sfrm(a[7:0], b[0], d[0]);
            "G": idle_cycles(a);
            "C": pulse_clear();
            "W": expect_write(a, b, d);
            "D": expect_done(a);
            "F": check_val(32'(dec_fsm), a, "dec_fsm");
            "E":
            begin
               check_val(32'(error_code), a, "error_code");
               check_val(32'(parity_err), b, "parity_err");
               check_val(32'(unk_instr_err), d, "unk_instr_err");
            end
            default: abort_run("unknown command letter in mdec_stim.txt");
         endcase
      end
   endtask

   // ******************************
   // main sequence
   // ******************************
   initial
   begin
      rstn          = 1'b0;
      mdec_sfrm     = '0;
      mdec_val      = 1'b0;
      clear_errors  = 1'b0;
      read_op       = 1'b0;
      read_byte_num = '0;
      repeat (4) @(posedge hsci_pclk);
      #5;
      rstn = 1'b1;

      check_val(32'(dec_en), 32'd0, "dec_en after reset");
      check_val(32'(dec_we), 32'd0, "dec_we after reset");
      check_val(32'(dec_addr), 32'd0, "dec_addr after reset");
      check_val(dec_data, 32'd0, "dec_data after reset");
      check_val(32'(read_done), 32'd0, "read_done after reset");
      check_val(32'(parity_err), 32'd0, "parity_err after reset");
      check_val(32'(unk_instr_err), 32'd0, "unk_instr_err after reset");
      check_val(32'(error_code), 32'd0, "error_code after reset");
      check_val(32'(dec_fsm), 32'(IDLE), "dec_fsm after reset");
      idle_cycles(3);
      check_val(32'(wr_seen), 32'd0, "writes while idle");

      fd = $fopen("mdec_stim.txt", "r");
      if (fd == 0)
         abort_run("cannot open mdec_stim.txt");
      else
      begin
         while (!$feof(fd))
         begin
            nf = $fgets(line, fd);
            if (nf > 1 && line[0] != "#")   // skip comments and blank lines
            begin
               cmd = line[0];
               nf  = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", fa, fb, fc);
               run_cmd(cmd, fa, fb, fc);
            end
         end
         $fclose(fd);
         check_val(32'(wr_addr_q.size()), 32'd0, "writes left unchecked");
         check_val(32'(done_len_q.size()), 32'd0, "read_done pulses left unchecked");
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

// ==== hsci_mdec_top.sv ====
module hsci_mdec_top
   import hsci_mdec_pkg::*;
(
   // clock, reset
   input  logic              hsci_pclk,
   input  logic              rstn,

   // subframes from the framer
   input  logic [SFRM_W-1:0] mdec_sfrm,
   input  logic              mdec_val,

   // dpram write port
   output logic [ADDR_W-1:0] dec_addr,
   output logic [DATA_W-1:0] dec_data,
   output logic              dec_en,
   output logic [LANES-1:0]  dec_we,

   // status and control
   output dec_state_t        dec_fsm,
   output logic [WORD_W-1:0] error_code,
   input  logic              clear_errors,
   output logic              parity_err,
   output logic              unk_instr_err,

   // read request from the encoder side
   input  logic              read_op,
   input  logic [BCNT_W-1:0] read_byte_num,
   output logic              read_done
);

   logic wr_stb;

   mdec_dec_if dec_if ();

   // ******************************
   // decode
   // ******************************
   mdec_frame_fsm u_frame_fsm
   (
      .hsci_pclk (hsci_pclk),
      .rstn      (rstn),
      .sfrm      (mdec_sfrm),
      .sfrm_val  (mdec_val),
      .dec_if    (dec_if.fsm),
      .dec_fsm   (dec_fsm)
   );

   mdec_err_regs u_err_regs
   (
      .hsci_pclk     (hsci_pclk),
      .rstn          (rstn),
      .dec_if        (dec_if.sink),
      .clear_errors  (clear_errors),
      .parity_err    (parity_err),
      .unk_instr_err (unk_instr_err),
      .error_code    (error_code)
   );

   // ******************************
   // read data path
   // ******************************
   mdec_rdata_pack u_rdata_pack
   (
      .hsci_pclk (hsci_pclk),
      .rstn      (rstn),
      .dec_if    (dec_if.sink),
      .read_done (read_done),
      .wr_stb    (wr_stb),
      .dec_en    (dec_en),
      .dec_we    (dec_we),
      .dec_addr  (dec_addr),
      .dec_data  (dec_data)
   );

   mdec_read_tally u_read_tally
   (
      .hsci_pclk     (hsci_pclk),
      .rstn          (rstn),
      .read_op       (read_op),
      .read_byte_num (read_byte_num),
      .wr_stb        (wr_stb),
      .read_done     (read_done)
   );

endmodule

// ==== mdec_read_tally.sv ====
module mdec_read_tally
   import hsci_mdec_pkg::*;
(
   input  logic              hsci_pclk,
   input  logic              rstn,
   input  logic              read_op,
   input  logic [BCNT_W-1:0] read_byte_num,
   input  logic              wr_stb,
   output logic              read_done
);

   logic [BCNT_W-1:0] byte_cnt;
   logic              read_done_d;

   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         read_done_d <= 1'b0;
      else
         read_done_d <= read_done;
   end

   // ******************************
   // stored byte count
   // ******************************
   // read_byte_num is the byte count less one, so done when cnt passes it
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         byte_cnt  <= '0;
         read_done <= 1'b0;
      end
      else if (read_op)
      begin
         byte_cnt  <= '0;   // new request
         read_done <= 1'b0;
      end
      else if (wr_stb)
      begin
         byte_cnt <= byte_cnt + 1'b1;
      end
      else if (byte_cnt > read_byte_num)
      begin
         byte_cnt  <= '0;
         read_done <= 1'b1;
      end
      else if (read_done_d)
      begin
         read_done <= 1'b0;   // drop after the second cycle
      end
   end

endmodule

// ==== mdec_rdata_pack.sv ====
module mdec_rdata_pack
   import hsci_mdec_pkg::*;
(
   input  logic              hsci_pclk,
   input  logic              rstn,
   mdec_dec_if.sink          dec_if,
   input  logic              read_done,
   output logic              wr_stb,
   output logic              dec_en,
   output logic [LANES-1:0]  dec_we,
   output logic [ADDR_W-1:0] dec_addr,
   output logic [DATA_W-1:0] dec_data
);

   logic [LANE_W-1:0] lane_cnt;
   logic              read_done_d;
   logic              rewind;
   logic [DATA_W-1:0] byte_ext;

   // second cycle of read_done
   assign rewind   = read_done & read_done_d;
   assign byte_ext = {{(DATA_W-WORD_W){1'b0}}, dec_if.word.data};

   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         read_done_d <= 1'b0;
      else
         read_done_d <= read_done;
   end

   // ******************************
   // byte lane write
   // ******************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         dec_en   <= 1'b0;
         dec_we   <= '0;
         dec_data <= '0;
         lane_cnt <= '0;
      end
      else if (dec_if.data_stb)
      begin
         dec_en   <= 1'b1;
         dec_we   <= LANES'(1) << lane_cnt;              // one enable per byte
         dec_data <= byte_ext << (WORD_W * lane_cnt);
         lane_cnt <= lane_cnt + 1'b1;                    // wraps after lane 3
      end
      else
      begin
         dec_en   <= 1'b0;
         dec_we   <= '0;
         dec_data <= '0;
         if (rewind)
            lane_cnt <= '0;
      end
   end

   // ******************************
   // word address
   // ******************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         dec_addr <= '0;
      else if (dec_we[LANES-1])   // top lane just written
         dec_addr <= dec_addr + 1'b1;
      else if (rewind)
         dec_addr <= '0;          // next read starts at word 0
   end

   assign wr_stb = dec_en;   // store pulse to the byte tally

endmodule

// ==== mdec_err_regs.sv ====
module mdec_err_regs
   import hsci_mdec_pkg::*;
(
   input  logic              hsci_pclk,
   input  logic              rstn,
   mdec_dec_if.sink          dec_if,
   input  logic              clear_errors,
   output logic              parity_err,
   output logic              unk_instr_err,
   output logic [WORD_W-1:0] error_code
);

   logic par_bad;

   // odd parity over word, cont and par
   assign par_bad = dec_if.val & ~(^{dec_if.word.data, dec_if.cont, dec_if.par});

   // ******************************
   // sticky status where set beats clear
   // ******************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         parity_err <= 1'b0;
      else if (par_bad)
         parity_err <= 1'b1;
      else if (clear_errors)
         parity_err <= 1'b0;
   end

   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         unk_instr_err <= 1'b0;
      else if (dec_if.unk_stb)
         unk_instr_err <= 1'b1;
      else if (clear_errors)
         unk_instr_err <= 1'b0;
   end

   // code byte that follows an error message header
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         error_code <= '0;
      else if (dec_if.errmsg_stb)
         error_code <= dec_if.word.data;
      else if (clear_errors)
         error_code <= '0;
   end

endmodule

// ==== mdec_frame_fsm.sv ====
module mdec_frame_fsm
   import hsci_mdec_pkg::*;
(
   input  logic              hsci_pclk,
   input  logic              rstn,
   input  logic [SFRM_W-1:0] sfrm,
   input  logic              sfrm_val,
   mdec_dec_if.fsm           dec_if,
   output dec_state_t        dec_fsm
);

   dec_state_t dec_state;
   dec_state_t dec_next;

   // ******************************
   // subframe split
   // ******************************
   assign dec_if.word = mdec_word_u'(sfrm[SFRM_W-1:2]);
   assign dec_if.par  = sfrm[1];
   assign dec_if.cont = sfrm[0];
   assign dec_if.val  = sfrm_val;

   // one byte qualifier per phase
   assign dec_if.data_stb   = sfrm_val & (dec_state == RDATA);
   assign dec_if.errmsg_stb = sfrm_val & (dec_state == ERROR);
   assign dec_if.unk_stb    = sfrm_val & (dec_state == MERR);

   // ******************************
   // next state
   // ******************************
   always_comb
   begin
      dec_next = dec_state;
      if (sfrm_val)
      begin
         case (dec_state)
            IDLE:
            begin
               if (dec_if.word.hdr.start)   // stray non-header bytes ignored
               begin
                  if (dec_if.word.hdr.instr == INSTR_READ_ACK)
                     dec_next = RINDEX;
                  else if (dec_if.word.hdr.instr == INSTR_ERR_MSG)
                     dec_next = ERROR;
                  else
                     dec_next = MERR;
               end
            end

            RINDEX:
            begin
               // index bytes dropped up to the one with cont low
               if (!dec_if.cont)
                  dec_next = RDATA;
            end

            RDATA:
            begin
               if (!dec_if.cont)
                  dec_next = IDLE;
            end

            ERROR,
            MERR:
            begin
               dec_next = IDLE;   // single byte phases
            end

            default:
            begin
               dec_next = IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
         dec_state <= IDLE;
      else
         dec_state <= dec_next;
   end

   assign dec_fsm = dec_state;   // status readback

endmodule

// ==== mdec_dec_if.sv ====
interface mdec_dec_if
   import hsci_mdec_pkg::*;
();

   mdec_word_u word;   // subframe payload
   logic       par;    // odd parity bit
   logic       cont;   // low on the last word of a frame
   logic       val;

   // byte qualifiers from the frame fsm
   logic       data_stb;     // read data byte
   logic       errmsg_stb;   // error code byte
   logic       unk_stb;      // byte after an unknown header

   modport fsm
   (
      output word,
      output par,
      output cont,
      output val,
      output data_stb,
      output errmsg_stb,
      output unk_stb
   );

   modport sink
   (
      input word,
      input par,
      input cont,
      input val,
      input data_stb,
      input errmsg_stb,
      input unk_stb
   );

endinterface

// ==== hsci_mdec_pkg.sv ====
package hsci_mdec_pkg;

   // ******************************
   // widths
   // ******************************
   localparam int WORD_W = 8;                 // subframe payload
   localparam int SFRM_W = WORD_W + 2;        // word, parity, continue
   localparam int ADDR_W = 15;                // dpram word address
   localparam int DATA_W = 32;                // dpram data
   localparam int LANES  = DATA_W / WORD_W;   // byte lanes per word
   localparam int LANE_W = $clog2(LANES);
   localparam int BCNT_W = 17;                // read byte count

   // ******************************
   // header instruction codes
   // ******************************
   localparam logic [3:0] INSTR_READ_ACK = 4'b1010;
   localparam logic [3:0] INSTR_ERR_MSG  = 4'b1100;

   // decode fsm state codes
   typedef enum logic [2:0]
   {
      IDLE   = 3'b000,
      RINDEX = 3'b010,
      RDATA  = 3'b011,
      ERROR  = 3'b100,
      MERR   = 3'b111
   } dec_state_t;

   // one subframe word, seen as a frame header or as a payload byte
   typedef union packed
   {
      struct packed
      {
         logic       start;   // set on the first word of a frame
         logic [3:0] instr;
         logic [2:0] size;
      } hdr;
      logic [WORD_W-1:0] data;
   } mdec_word_u;

endpackage
